/* isaPkg.sv */
package isaPkg;

	typedef logic [15:0] word_t;	// Data and address word
	typedef logic [3:0] opcode_t;
	typedef logic [5:0] func_t;	// R-type function code
	typedef logic [1:0] regIdx_t;
	typedef logic [7:0] imm_t;

	// Opcodes in bits 15 to 12
	localparam opcode_t opBne = 4'd0;
	localparam opcode_t opBeq = 4'd1;
	localparam opcode_t opBgz = 4'd2;
	localparam opcode_t opBlz = 4'd3;
	localparam opcode_t opAdi = 4'd4;
	localparam opcode_t opOri = 4'd5;
	localparam opcode_t opLhi = 4'd6;
	localparam opcode_t opLwd = 4'd7;
	localparam opcode_t opSwd = 4'd8;
	localparam opcode_t opJmp = 4'd9;
	localparam opcode_t opJal = 4'd10;
	localparam opcode_t opRtype = 4'd15;

	// Function codes for opcode 15
	localparam func_t funcAdd = 6'd0;
	localparam func_t funcSub = 6'd1;
	localparam func_t funcAnd = 6'd2;
	localparam func_t funcOrr = 6'd3;
	localparam func_t funcNot = 6'd4;
	localparam func_t funcTcp = 6'd5;
	localparam func_t funcShl = 6'd6;
	localparam func_t funcShr = 6'd7;
	localparam func_t funcJpr = 6'd25;
	localparam func_t funcJrl = 6'd26;
	localparam func_t funcWwd = 6'd28;
	localparam func_t funcHlt = 6'd29;

	localparam regIdx_t linkReg = 2'd2;	// JAL and JRL return address

	// Field extraction
	function automatic opcode_t opcodeOf(word_t inst);
		return inst[15:12];
	endfunction

	function automatic func_t funcOf(word_t inst);
		return inst[5:0];
	endfunction

	function automatic regIdx_t rsOf(word_t inst);
		return inst[11:10];
	endfunction

	function automatic regIdx_t rtOf(word_t inst);
		return inst[9:8];
	endfunction

	function automatic regIdx_t rdOf(word_t inst);
		return inst[7:6];
	endfunction

	function automatic imm_t immOf(word_t inst);
		return inst[7:0];
	endfunction

endpackage

/* ctrlPkg.sv */
package ctrlPkg;

	// Micro-states of one instruction
	typedef enum logic [2:0] {
		IF1,
		IF2,
		IF3,
		ID,
		EX,
		MEM1,
		MEM2,
		WB
	} microState_t;

	typedef enum logic [3:0] {
		ADD,
		SUB,
		AND,
		OR,
		NOT,	// Operates on a only
		TCP,
		ALS,
		ARS,
		ZERO
	} aluOp_t;

	// Registered by the control unit and consumed by the datapath
	typedef struct packed {
		logic jumpReg;	// PC from rs
		logic jumpImm;	// PC from 12-bit target
		logic branch;
		logic linkWrite;	// Write PC+1 to link register
		logic lhiSel;
		logic memToReg;
		logic memWrite;
		logic regWrite;
		logic regDstRd;	// rd rather than rt
		aluOp_t aluOp;
		logic aluSrcImm;
		logic zeroExtImm;
	} ctrlSignals_t;

endpackage

/* alu.sv */
module alu import isaPkg::*, ctrlPkg::*; (
	input word_t a,
	input word_t b,
	input aluOp_t op,
	output word_t result
);

	always_comb begin
		case (op)
			ADD: result = a + b;
			SUB: result = a - b;
			AND: result = a & b;
			OR: result = a | b;
			NOT: result = ~a;
			TCP: result = ~a + 16'd1;	// Negate a
			ALS: result = {a[14:0], 1'b0};
			ARS: result = {a[15], a[15:1]};	// Sign bit kept
			ZERO: result = '0;
			default: result = '0;
		endcase
	end

endmodule

/* registerFile.sv */
module registerFile import isaPkg::*; (
	input logic clk,
	input logic reset_n,
	input regIdx_t readA,
	input regIdx_t readB,
	input regIdx_t writeIdx,
	input logic writeEn,
	input word_t writeData,
	output word_t dataA,
	output word_t dataB
);

	word_t regs [4];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < 4; i++)
				regs[i] <= '0;
		end else if (writeEn) begin
			regs[writeIdx] <= writeData;
		end
	end

	// Combinational read without bypass of a same-cycle write
	assign dataA = regs[readA];
	assign dataB = regs[readB];

endmodule

/* controlUnit.sv */
module controlUnit import isaPkg::*, ctrlPkg::*; (
	input logic clk,
	input logic reset_n,
	input word_t instruction,
	output microState_t state,
	output ctrlSignals_t ctrl,
	output word_t numInst,
	output logic isHalted
);

	opcode_t opcode;
	func_t func;
	microState_t nextState;
	logic isJump;
	logic isHlt;

	// Controls for one instruction
	function automatic ctrlSignals_t decode(opcode_t op, func_t fn);
		ctrlSignals_t c;
		c = '0;
		c.aluOp = ZERO;
		case (op)
			opRtype: begin
				case (fn)
					funcAdd, funcSub, funcAnd, funcOrr,
					funcNot, funcTcp, funcShl, funcShr: begin
						c.regWrite = 1'b1;
						c.regDstRd = 1'b1;
					end
					funcJpr: c.jumpReg = 1'b1;
					funcJrl: begin
						c.jumpReg = 1'b1;
						c.linkWrite = 1'b1;
						c.regWrite = 1'b1;
					end
					default: ;	// WWD and HLT need no controls
				endcase
				case (fn)
					funcAdd: c.aluOp = ADD;
					funcSub: c.aluOp = SUB;
					funcAnd: c.aluOp = AND;
					funcOrr: c.aluOp = OR;
					funcNot: c.aluOp = NOT;
					funcTcp: c.aluOp = TCP;
					funcShl: c.aluOp = ALS;
					funcShr: c.aluOp = ARS;
					default: c.aluOp = ZERO;
				endcase
			end
			opAdi: begin
				c.regWrite = 1'b1;
				c.aluOp = ADD;
				c.aluSrcImm = 1'b1;
			end
			opOri: begin
				c.regWrite = 1'b1;
				c.aluOp = OR;
				c.aluSrcImm = 1'b1;
				c.zeroExtImm = 1'b1;
			end
			opLhi: begin
				c.regWrite = 1'b1;
				c.lhiSel = 1'b1;
			end
			opLwd: begin
				c.regWrite = 1'b1;
				c.memToReg = 1'b1;
				c.aluOp = ADD;	// Base plus offset
				c.aluSrcImm = 1'b1;
			end
			opSwd: begin
				c.memWrite = 1'b1;
				c.aluOp = ADD;
				c.aluSrcImm = 1'b1;
			end
			opBne, opBeq, opBgz, opBlz: c.branch = 1'b1;
			opJmp: c.jumpImm = 1'b1;
			opJal: begin
				c.jumpImm = 1'b1;
				c.linkWrite = 1'b1;
				c.regWrite = 1'b1;
			end
			default: ;
		endcase
		return c;
	endfunction

	assign opcode = opcodeOf(instruction);
	assign func = funcOf(instruction);
	assign isJump = (opcode == opJmp) || (opcode == opJal);
	assign isHlt = (opcode == opRtype) && (func == funcHlt);

	always_comb begin
		nextState = IF1;
		case (state)
			IF1: nextState = IF2;
			IF2: nextState = IF3;
			IF3: nextState = isJump ? EX : ID;	// JMP and JAL skip decode
			ID: nextState = isHlt ? ID : EX;
			EX: begin
				if ((opcode == opLwd) || (opcode == opSwd))
					nextState = MEM1;
				else if ((opcode == opRtype) && (func != funcWwd) && (func != funcJpr))
					nextState = WB;
				else if ((opcode >= opAdi && opcode <= opLhi) || (opcode == opJal))
					nextState = WB;
				else
					nextState = IF1;	// Branches, JMP, JPR, WWD
			end
			MEM1: nextState = MEM2;
			MEM2: nextState = (opcode == opLwd) ? WB : IF1;
			default: nextState = IF1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= IF1;
			ctrl <= '0;
			numInst <= '1;	// First fetch brings it to 0
			isHalted <= 1'b0;
		end else if (!isHalted) begin
			state <= nextState;
			if (state == IF1)
				numInst <= numInst + 16'd1;
			if ((state == IF3 && isJump) || state == ID)
				ctrl <= decode(opcode, func);
			if (state == ID && isHlt)
				isHalted <= 1'b1;
		end
	end

endmodule

/* datapath.sv */
module datapath import isaPkg::*, ctrlPkg::*; #(
	parameter word_t resetPc = '0
) (
	input logic clk,
	input logic reset_n,
	input microState_t state,
	input ctrlSignals_t ctrl,
	output word_t instruction,
	output word_t memAddr,
	output logic memRead,
	output logic memWrite,
	output word_t memWriteData,
	input word_t memReadData,
	output word_t outputPort,
	output logic outputStrobe
);

	word_t pc, ir;
	word_t rsVal, rtVal;
	word_t immSigned, immExt, aluB, aluResult;
	word_t resultReg, storeData, memData;	// Latched in EX and MEM2
	word_t branchTarget, jumpTarget, writeData;
	regIdx_t writeIdx;
	logic fetching, inMem, branchCond, isWwd;

	assign instruction = ir;

	registerFile regs (
		.clk(clk), .reset_n(reset_n),
		.readA(rsOf(ir)), .readB(rtOf(ir)),
		.writeIdx(writeIdx), .writeEn(state == WB && ctrl.regWrite),
		.writeData(writeData),
		.dataA(rsVal), .dataB(rtVal)
	);

	assign immSigned = {{8{ir[7]}}, immOf(ir)};
	assign immExt = ctrl.zeroExtImm ? {8'h00, immOf(ir)} : immSigned;
	assign aluB = ctrl.aluSrcImm ? immExt : rtVal;

	alu aluUnit (.a(rsVal), .b(aluB), .op(ctrl.aluOp), .result(aluResult));

	always_comb begin
		case (opcodeOf(ir))
			opBne: branchCond = (rsVal != rtVal);
			opBeq: branchCond = (rsVal == rtVal);
			opBgz: branchCond = ($signed(rsVal) > 0);
			opBlz: branchCond = ($signed(rsVal) < 0);
			default: branchCond = 1'b0;
		endcase
	end

	// pc already holds PC+1 from EX onward
	assign branchTarget = pc + immSigned;
	assign jumpTarget = {pc[15:12], ir[11:0]};
	assign isWwd = (opcodeOf(ir) == opRtype) && (funcOf(ir) == funcWwd);

	assign writeIdx = ctrl.linkWrite ? linkReg : (ctrl.regDstRd ? rdOf(ir) : rtOf(ir));
	assign writeData = ctrl.memToReg ? memData : resultReg;

	assign fetching = (state == IF1) || (state == IF2) || (state == IF3);
	assign inMem = (state == MEM1) || (state == MEM2);
	assign memAddr = inMem ? resultReg : pc;
	assign memRead = fetching || (inMem && ctrl.memToReg);
	assign memWrite = (state == MEM2) && ctrl.memWrite;	// Single write edge
	assign memWriteData = storeData;
	assign outputStrobe = (state == EX) && isWwd;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc <= resetPc;
			ir <= '0;
			outputPort <= '0;
		end else begin
			if (fetching)
				ir <= memReadData;	// Address held, so the word is stable
			if (state == IF3)
				pc <= pc + 16'd1;
			if (state == EX) begin
				if (ctrl.jumpImm)
					pc <= jumpTarget;
				else if (ctrl.jumpReg)
					pc <= rsVal;
				else if (ctrl.branch && branchCond)
					pc <= branchTarget;
				if (isWwd)
					outputPort <= rsVal;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == EX) begin
			if (ctrl.linkWrite)
				resultReg <= pc;	// Return address
			else if (ctrl.lhiSel)
				resultReg <= {immOf(ir), 8'h00};
			else
				resultReg <= aluResult;
			storeData <= rtVal;
		end
		if (state == MEM2)
			memData <= memReadData;
	end

endmodule

/* cpuTop.sv */
module cpuTop import isaPkg::*, ctrlPkg::*; #(
	parameter word_t resetPc = '0
) (
	input logic clk,
	input logic reset_n,
	output word_t memAddr,
	output logic memRead,
	output logic memWrite,
	output word_t memWriteData,
	input word_t memReadData,
	output word_t outputPort,
	output logic outputStrobe,
	output word_t numInst,
	output logic isHalted
);

	microState_t state;
	ctrlSignals_t ctrl;
	word_t instruction;

	controlUnit control (
		.clk(clk),
		.reset_n(reset_n),
		.instruction(instruction),
		.state(state),
		.ctrl(ctrl),
		.numInst(numInst),
		.isHalted(isHalted)
	);

	datapath #(.resetPc(resetPc)) path (
		.clk(clk),
		.reset_n(reset_n),
		.state(state),
		.ctrl(ctrl),
		.instruction(instruction),
		.memAddr(memAddr),
		.memRead(memRead),
		.memWrite(memWrite),
		.memWriteData(memWriteData),
		.memReadData(memReadData),
		.outputPort(outputPort),
		.outputStrobe(outputStrobe)
	);

endmodule

/* tbCpuModel.sv */
module cpuModel import isaPkg::*; #(
	parameter int progLen = 60
) ();

	word_t prog [256];	// Program and data image
	word_t outQ [$];	// Expected WWD values
	word_t storeAddrQ [$];
	word_t storeDataQ [$];
	word_t pcQ [$];	// Fetch addresses in order
	int instCount;

	function automatic word_t rTypeWord(regIdx_t rs, regIdx_t rt, regIdx_t rd, func_t fn);
		return {opRtype, rs, rt, rd, fn};
	endfunction

	function automatic word_t immWord(opcode_t op, regIdx_t rs, regIdx_t rt, imm_t imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic regIdx_t pickReg();
		return regIdx_t'($urandom_range(0, 3));
	endfunction

	task automatic buildProgram(input word_t base);
		bit inner [progLen + 4];	// Second or third word of a sequence
		int at, i, k, kind;
		word_t stub;
		regIdx_t a;
		inner = '{default: 1'b0};
		stub = base + word_t'(progLen);	// JPR back through the link register
		for (int n = 0; n < 256; n++)
			prog[n] = {n[7:0] ^ 8'hC3, n[7:0]};
		i = 0;
		while (i < progLen - 1) begin
			at = int'(base) + i;
			a = pickReg();
			kind = $urandom_range(0, 12);
			if ((kind == 9 || kind == 11) && i + 3 > progLen - 1)
				kind = 6;	// No room left for three words
			case (kind)
				0, 1, 2: prog[at] = rTypeWord(a, pickReg(), pickReg(),
						func_t'($urandom_range(0, 7)));
				3: prog[at] = immWord(opAdi, a, pickReg(), imm_t'($urandom));
				4: prog[at] = immWord(opOri, a, pickReg(), imm_t'($urandom));
				5: prog[at] = immWord(opLhi, 2'd0, a, imm_t'($urandom));
				7: prog[at] = immWord(opcode_t'($urandom_range(0, 3)), a, pickReg(), 8'd0);
				8: prog[at] = {opJmp, 12'd0};
				10: prog[at] = {opJal, stub[11:0]};
				9, 11: begin
					prog[at] = immWord(opLhi, 2'd0, a, 8'h00);
					if (kind == 9) begin
						// Base in 128..191 and offset 0..63 keep it in the data region
						prog[at + 1] = immWord(opOri, a, a, imm_t'($urandom_range(128, 191)));
						prog[at + 2] = immWord($urandom_range(0, 1) ? opLwd : opSwd, a, pickReg(),
								imm_t'($urandom_range(0, 63)));
					end else begin
						prog[at + 1] = immWord(opOri, a, a, stub[7:0]);
						prog[at + 2] = rTypeWord(a, 2'd0, 2'd0, funcJrl);
					end
					inner[i + 1] = 1'b1;
					inner[i + 2] = 1'b1;
					i += 2;
				end
				default: prog[at] = rTypeWord(a, 2'd0, 2'd0, funcWwd);
			endcase
			i++;
		end
		// Forward targets only and never into a sequence
		for (i = 0; i < progLen - 1; i++) begin
			at = int'(base) + i;
			if (!inner[i] && (prog[at][15:12] <= opBlz || prog[at][15:12] == opJmp)) begin
				k = $urandom_range(0, 3);
				while (i + 1 + k > progLen - 1 || inner[i + 1 + k])
					k--;
				if (prog[at][15:12] == opJmp)
					prog[at][11:0] = 12'(int'(base) + i + 1 + k);
				else
					prog[at][7:0] = imm_t'(k);
			end
		end
		prog[int'(base) + progLen - 1] = rTypeWord(2'd0, 2'd0, 2'd0, funcHlt);
		prog[stub[7:0]] = rTypeWord(linkReg, 2'd0, 2'd0, funcJpr);
	endtask

	task automatic runProgram(input word_t base);
		word_t dataMem [256];
		word_t r [4];
		word_t pc, inst, a, b, imm, addr;
		regIdx_t rt, rd;
		bit halted;
		dataMem = prog;
		r = '{default: '0};
		outQ.delete();
		storeAddrQ.delete();
		storeDataQ.delete();
		pcQ.delete();
		pc = base;
		halted = 1'b0;
		instCount = 0;
		while (!halted && instCount < 4 * progLen) begin
			pcQ.push_back(pc);
			inst = dataMem[pc[7:0]];
			instCount++;
			pc = pc + 16'd1;	// Targets are relative to the next word
			a = r[inst[11:10]];
			b = r[inst[9:8]];
			rt = inst[9:8];
			rd = inst[7:6];
			imm = {{8{inst[7]}}, inst[7:0]};
			addr = a + imm;
			case (inst[15:12])
				opBne: if (a != b) pc = pc + imm;
				opBeq: if (a == b) pc = pc + imm;
				opBgz: if ($signed(a) > 0) pc = pc + imm;
				opBlz: if ($signed(a) < 0) pc = pc + imm;
				opAdi: r[rt] = a + imm;
				opOri: r[rt] = a | {8'h00, inst[7:0]};
				opLhi: r[rt] = {inst[7:0], 8'h00};
				opLwd: r[rt] = dataMem[addr[7:0]];
				opSwd: begin
					dataMem[addr[7:0]] = b;
					storeAddrQ.push_back(addr);
					storeDataQ.push_back(b);
				end
				opJmp: pc = {pc[15:12], inst[11:0]};
				opJal: begin
					r[linkReg] = pc;
					pc = {pc[15:12], inst[11:0]};
				end
				opRtype: begin
					case (inst[5:0])
						funcAdd: r[rd] = a + b;
						funcSub: r[rd] = a - b;
						funcAnd: r[rd] = a & b;
						funcOrr: r[rd] = a | b;
						funcNot: r[rd] = ~a;
						funcTcp: r[rd] = 16'd0 - a;
						funcShl: r[rd] = a << 1;
						funcShr: r[rd] = $signed(a) >>> 1;
						funcWwd: outQ.push_back(a);
						funcJpr: pc = a;
						funcJrl: begin
							r[linkReg] = pc;	// Old rs already read
							pc = a;
						end
						funcHlt: halted = 1'b1;
						default: ;
					endcase
				end
				default: ;
			endcase
		end
	endtask

endmodule

/* cpuTb.sv */
module cpuTb import isaPkg::*, ctrlPkg::*; ();

	localparam word_t resetPc = 16'h0010;	// Program base away from zero
	localparam int progLen = 60;
	localparam int numPrograms = 3;
	localparam int clkPeriod = 8;
	// Eight cycles per instruction at most with a margin of two
	localparam int watchdogTime = numPrograms * progLen * 8 * clkPeriod * 2;

	logic clk;
	logic reset_n;
	logic loadMem;	// Copy the model image into memory
	word_t memAddr, memWriteData, memReadData, outputPort, numInst;
	logic memRead, memWrite, outputStrobe, isHalted;
	word_t mem [256];
	int errorCount;
	int checkCount;

	cpuTop #(.resetPc(resetPc)) UUT (
		.clk(clk),
		.reset_n(reset_n),
		.memAddr(memAddr),
		.memRead(memRead),
		.memWrite(memWrite),
		.memWriteData(memWriteData),
		.memReadData(memReadData),
		.outputPort(outputPort),
		.outputStrobe(outputStrobe),
		.numInst(numInst),
		.isHalted(isHalted)
	);

	cpuModel #(.progLen(progLen)) model ();

	always #(clkPeriod / 2) clk = ~clk;

	assign memReadData = mem[memAddr[7:0]];	// Answers in the same cycle

	always @(posedge clk) begin
		if (loadMem) begin
			for (int n = 0; n < 256; n++)
				mem[n] <= model.prog[n];
		end else if (memWrite) begin
			mem[memAddr[7:0]] <= memWriteData;
		end
	end

	task automatic checkWord(input string name, input word_t got, input word_t expected);
		checkCount++;
		if (got !== expected) begin
			errorCount++;
			$display("ERROR %s: got 0x%h, expected 0x%h at %0t", name, got, expected, $time);
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic expected);
		checkCount++;
		if (got !== expected) begin
			errorCount++;
			$display("ERROR %s: got 0x%h, expected 0x%h at %0t", name, got, expected, $time);
		end
	endtask

	task automatic reportFailure(input string what);
		errorCount++;
		$display("%s at %0t", what, $time);
	endtask

	// Two reset edges and then the first IF1
	task automatic applyReset();
		@(posedge clk);
		#1;
		reset_n = 1'b0;
		loadMem = 1'b1;
		@(posedge clk);
		@(negedge clk);
		checkFlag("memWrite", memWrite, 1'b0);
		checkFlag("outputStrobe", outputStrobe, 1'b0);
		checkFlag("isHalted", isHalted, 1'b0);
		@(posedge clk);
		#1;
		reset_n = 1'b1;
		loadMem = 1'b0;
		@(negedge clk);
		checkFlag("memWrite", memWrite, 1'b0);
		checkFlag("outputStrobe", outputStrobe, 1'b0);
		checkFlag("isHalted", isHalted, 1'b0);
		checkWord("memAddr", memAddr, resetPc);
	endtask

	task automatic followProgram();
		int outIdx;
		int storeIdx;
		int pcIdx;
		logic outPending;
		outIdx = 0;
		storeIdx = 0;
		pcIdx = 0;
		outPending = 1'b0;
		while (!isHalted) begin
			if (outPending) begin
				if (outIdx < model.outQ.size())
					checkWord("outputPort", outputPort, model.outQ[outIdx]);
				else
					reportFailure("WWD output that the model does not expect");
				outIdx++;
			end
			outPending = outputStrobe;	// Port loads at the end of EX
			if (UUT.state == IF1) begin
				checkFlag("memRead", memRead, 1'b1);
				if (pcIdx < model.pcQ.size())
					checkWord("memAddr", memAddr, model.pcQ[pcIdx]);
				else
					reportFailure("fetch past the end of the expected program");
				pcIdx++;
			end
			if (memWrite) begin
				if (storeIdx < model.storeAddrQ.size()) begin
					checkWord("memAddr", memAddr, model.storeAddrQ[storeIdx]);
					checkWord("memWriteData", memWriteData, model.storeDataQ[storeIdx]);
				end else begin
					reportFailure("memory write that the model does not expect");
				end
				storeIdx++;
			end
			@(negedge clk);
		end
		if (outIdx != model.outQ.size())
			reportFailure("number of WWD outputs differs from the model");
		if (storeIdx != model.storeAddrQ.size())
			reportFailure("number of memory writes differs from the model");
		if (pcIdx != model.pcQ.size())
			reportFailure("number of fetches differs from the model");
	endtask

	// Halt state must hold
	task automatic checkHalt();
		word_t expCount;
		expCount = word_t'(model.instCount - 1);
		repeat (11) begin
			checkFlag("isHalted", isHalted, 1'b1);
			checkWord("numInst", numInst, expCount);
			checkFlag("outputStrobe", outputStrobe, 1'b0);
			@(negedge clk);
		end
	endtask

	initial begin
		clk = 1'b0;
		reset_n = 1'b0;
		loadMem = 1'b0;
		errorCount = 0;
		checkCount = 0;
		void'($urandom(58));
		repeat (numPrograms) begin
			model.buildProgram(resetPc);
			model.runProgram(resetPc);
			applyReset();
			followProgram();
			checkHalt();
		end
		$display("Programs %0d, checks %0d, errors %0d", numPrograms, checkCount, errorCount);
		if (errorCount == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	initial begin
		#(watchdogTime);
		$display("processor did not halt, %0d errors so far", errorCount);
		$display("Test FAILED");
		$finish;
	end

endmodule

/* flist.f */
isaPkg.sv
ctrlPkg.sv
alu.sv
registerFile.sv
controlUnit.sv
datapath.sv
cpuTop.sv
tbCpuModel.sv
cpuTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= cpuTb
FLIST ?= flist.f
SEED ?= 58
LOG ?= sim.log
BUILD ?= obj_dir
VFLAGS ?= --binary --timing -j 0

SOURCES := $(shell cat $(FLIST))
SIM := $(BUILD)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST SEED LOG BUILD VFLAGS"

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

test: $(SIM)
	-$(SIM) +verilator+seed+$(SEED) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Test OK$$" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
